// File: videoTimingPkg.sv
// Beam timing definitions shared by the counter, the layer stages
// and the fetch stage

package videoTimingPkg;

	//////////////////////////////
	// Counter sizes
	//////////////////////////////

	// Horizontal counter width, 512 pixel clocks per line at most
	localparam int hCount = 9;

	// Vertical counter width, 512 lines per frame at most
	localparam int vCount = 9;

	// H bit that splits RAM time between the layers
	// Toggles every two pixel clocks
	localparam int phaseBit = 1;

	//////////////////////////////
	// Beam position
	//////////////////////////////

	// Registered beam position as seen by the layer stages
	// Phase is a copy of h bit 1
	// 0 selects layer A, 1 selects layer B
	typedef struct packed {
		logic [hCount-1:0] h;
		logic [vCount-1:0] v;
		logic              phase;
	} beamPos;

endpackage

// File: tilemapPkg.sv
// Tilemap layer definitions
// Scroll settings, RAM fetch words and tile code sizes

package tilemapPkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// Two scrolling layers, A and B
	localparam int numLayers = 2;

	// Scroll offsets cover the full 512 counter range
	localparam int scrollW = 9;
	localparam int bankW   = 3;

	// Pixel offset inside an 8x8 tile
	localparam int fineW = 3;

	// 64 columns by 32 rows of tiles per layer
	localparam int tileColW = 6;
	localparam int tileRowW = 5;

	// Per-layer RAM address, row + column + byte select
	localparam int layerAddrW = tileRowW + tileColW + 1;

	// Layer bit on top of the per-layer address
	localparam int ramAddrW = layerAddrW + 1;

	// Tile code, low byte plus 3 bits from the attribute byte
	localparam int codeHighW = 3;
	localparam int tileCodeW = 8 + codeHighW;

	// Graphics ROM address, tile code then fine Y
	localparam int gfxAddrW = tileCodeW + fineW;

	//////////////////////////////
	// Register map, low 2 bits
	//////////////////////////////

	localparam logic [1:0] regScrollXHigh = 2'd0;
	localparam logic [1:0] regScrollXLow  = 2'd1;
	localparam logic [1:0] regScrollY     = 2'd2;
	localparam logic [1:0] regBank        = 2'd3;

	//////////////////////////////
	// Structs
	//////////////////////////////

	// Settings for one layer as written by the CPU
	typedef struct packed {
		logic [scrollW-1:0] scrollX;
		logic [scrollW-1:0] scrollY;
		logic [bankW-1:0]   bank;
	} layerScroll;

	// Tilemap RAM word address inside one layer
	typedef struct packed {
		logic [tileRowW-1:0] row;
		logic [tileColW-1:0] col;
		logic                byteSel;
	} tileAddr;

	// One layer stage output per pixel clock
	typedef struct packed {
		tileAddr          ramAddr;
		logic [fineW-1:0] fineX;
		logic [fineW-1:0] fineY;
	} layerFetch;

endpackage

// File: beamCounter.sv
`timescale 1ns/10ps

// Beam counters locked to the external sync strobes
module beamCounter (
	input  logic                   CLK_6M,
	input  logic                   rstN,
	input  logic                   hSyncN,
	input  logic                   vSyncN,
	output videoTimingPkg::beamPos beam
);

	// Previous strobe levels
	logic hSyncD;
	logic vSyncD;

	// Falling edge seen this cycle
	logic hFall;
	logic vFall;

	logic [videoTimingPkg::hCount-1:0] hReg;
	logic [videoTimingPkg::vCount-1:0] vReg;

	assign hFall = hSyncD & ~hSyncN;
	assign vFall = vSyncD & ~vSyncN;

	// Strobes idle high, so reset to the idle level
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			hSyncD <= 1'b1;
			vSyncD <= 1'b1;
		end else begin
			hSyncD <= hSyncN;
			vSyncD <= vSyncN;
		end
	end

	// Horizontal position
	// Wraps at 512 if no strobe comes
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			hReg <= '0;
		end else if (hFall) begin
			hReg <= '0;
		end else begin
			hReg <= hReg + 1'b1;
		end
	end

	// Line count, steps once per line start
	// Frame start wins over the line step
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			vReg <= '0;
		end else if (vFall) begin
			vReg <= '0;
		end else if (hFall) begin
			vReg <= vReg + 1'b1;
		end
	end

	// Phase taken straight from the counter, no extra clock
	assign beam = '{h: hReg, v: vReg, phase: hReg[videoTimingPkg::phaseBit]};

endmodule

// File: scrollRegs.sv
`timescale 1ns/10ps

// CPU register port for the scroll and bank settings
//
// regAddr[2]   layer, 0 = A, 1 = B
// regAddr[1:0] field
//   0  scrollX bit 8 from data bit 0
//   1  scrollX low byte
//   2  scrollY low byte, bit 8 cleared
//   3  bank from data bits 2:0
module scrollRegs (
	input  logic                   CLK_6M,
	input  logic                   rstN,
	input  logic                   regWe,
	input  logic [2:0]             regAddr,
	input  logic [7:0]             regData,
	output tilemapPkg::layerScroll scrollA,
	output tilemapPkg::layerScroll scrollB
);

	// Settings of the addressed layer, before and after the write
	tilemapPkg::layerScroll current;
	tilemapPkg::layerScroll updated;

	assign current = regAddr[2] ? scrollB : scrollA;

	//////////////////////////////
	// Field decode
	//////////////////////////////

	// Only one field changes per write
	always_comb begin
		updated = current;
		case (regAddr[1:0])
			tilemapPkg::regScrollXHigh: begin
				updated.scrollX[tilemapPkg::scrollW-1] = regData[0];
			end
			tilemapPkg::regScrollXLow: begin
				updated.scrollX[7:0] = regData;
			end
			tilemapPkg::regScrollY: begin
				// Vertical scroll stays inside the 256-line map
				updated.scrollY = {1'b0, regData};
			end
			tilemapPkg::regBank: begin
				updated.bank = regData[tilemapPkg::bankW-1:0];
			end
		endcase
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Write pulse is one cycle wide
	// New value shows the cycle after
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			scrollA <= '0;
			scrollB <= '0;
		end else if (regWe) begin
			if (regAddr[2]) begin
				scrollB <= updated;
			end else begin
				scrollA <= updated;
			end
		end
	end

endmodule

// File: layerAddrGen.sv
`timescale 1ns/10ps

// One layer stage
// Beam position in, tilemap RAM address and fine offsets out
// One cycle from beam to fetch
module layerAddrGen (
	input  logic                   CLK_6M,
	input  logic                   rstN,
	input  logic                   flip,
	input  videoTimingPkg::beamPos beam,
	input  tilemapPkg::layerScroll scroll,
	output tilemapPkg::layerFetch  fetch
);

	//////////////////////////////
	// Screen to map coordinates
	//////////////////////////////

	// Beam coordinates after flip
	logic [videoTimingPkg::hCount-1:0] hView;
	logic [videoTimingPkg::vCount-1:0] vView;

	// Map coordinates, 512 wide and tall
	logic [tilemapPkg::scrollW-1:0] x;
	logic [tilemapPkg::scrollW-1:0] y;

	// Flipped screen counts backwards in both axes
	assign hView = flip ? ~beam.h : beam.h;
	assign vView = flip ? ~beam.v : beam.v;

	// Sums wrap at 512
	assign x = hView + scroll.scrollX;
	assign y = vView + scroll.scrollY;

	//////////////////////////////
	// Fetch word
	//////////////////////////////

	// Column from x bits 8:3
	// Row from y bits 7:3, only 32 rows in the map
	// Byte select follows the unflipped beam so both bytes
	// of a tile come out in the same order either way
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			fetch <= '0;
		end else begin
			fetch.ramAddr.row     <= y[tilemapPkg::fineW +: tilemapPkg::tileRowW];
			fetch.ramAddr.col     <= x[tilemapPkg::fineW +: tilemapPkg::tileColW];
			fetch.ramAddr.byteSel <= beam.h[0];
			// Pixel position inside the tile
			fetch.fineX           <= x[tilemapPkg::fineW-1:0];
			fetch.fineY           <= y[tilemapPkg::fineW-1:0];
		end
	end

endmodule

// File: tileFetchMux.sv
`timescale 1ns/10ps

// Tilemap RAM sharing and graphics address assembly
//
// Cycle t   beam on input
// Cycle t+1 layer fetch valid, RAM address out
// Cycle t+2 RAM data in, bytes captured
// Cycle t+3 graphics address and valid pulse
module tileFetchMux (
	input  logic                              CLK_6M,
	input  logic                              rstN,
	input  videoTimingPkg::beamPos            beam,
	input  tilemapPkg::layerFetch             fetchA,
	input  tilemapPkg::layerFetch             fetchB,
	// Layer bank attributes, outside the ROM address
	input  logic [2:0]                        bankA,
	input  logic [2:0]                        bankB,
	input  logic                              cpuSel,
	input  logic                              cpuWe,
	input  logic [tilemapPkg::ramAddrW-1:0]   cpuAddr,
	input  logic [7:0]                        cpuWrData,
	output logic [7:0]                        cpuRdData,
	output logic [tilemapPkg::ramAddrW-1:0]   ramAddr,
	output logic [7:0]                        ramWrData,
	input  logic [7:0]                        ramRdData,
	output logic                              ramWe,
	output logic                              ramOe,
	output logic [tilemapPkg::gfxAddrW-1:0]   gfxAddrA,
	output logic [tilemapPkg::gfxAddrW-1:0]   gfxAddrB,
	output logic                              gfxValidA,
	output logic                              gfxValidB,
	output logic                              hA2,
	output logic                              hB2
);

	// Address stage
	logic                               slotLayer;
	tilemapPkg::layerFetch              slotFetch;

	// Data stage, what the RAM is returning now
	logic                               rdVideo;
	logic                               rdLayer;
	logic                               rdByte;
	logic [tilemapPkg::fineW-1:0]       rdFineY;
	logic                               cpuRdPend;
	logic [7:0]                         cpuRdHold;

	// Low code bytes waiting for their attribute byte
	logic [7:0]                         codeLow [tilemapPkg::numLayers];
	logic [tilemapPkg::numLayers-1:0]   haveLow;
	logic [tilemapPkg::tileCodeW-1:0]   tileCode;
	logic                               fetchDone;

	//////////////////////////////
	// RAM port
	//////////////////////////////

	// Layer bit is the beam phase, delayed to line up with the fetch
	assign slotFetch = slotLayer ? fetchB : fetchA;

	// CPU takes the RAM outright
	assign ramAddr   = cpuSel ? cpuAddr : {slotLayer, slotFetch.ramAddr};
	assign ramWe     = cpuSel & cpuWe;
	assign ramOe     = cpuSel ? ~cpuWe : 1'b1;
	assign ramWrData = cpuWrData;

	// Read data straight from the RAM register, then held
	assign cpuRdData = cpuRdPend ? ramRdData : cpuRdHold;

	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			slotLayer <= 1'b0;
			rdVideo   <= 1'b0;
			rdLayer   <= 1'b0;
			cpuRdPend <= 1'b0;
		end else begin
			slotLayer <= beam.phase;
			rdVideo   <= ~cpuSel;
			rdLayer   <= slotLayer;
			cpuRdPend <= cpuSel & ~cpuWe;
		end
	end

	always_ff @(posedge CLK_6M) begin
		rdByte  <= slotFetch.ramAddr.byteSel;
		rdFineY <= slotFetch.fineY;
		if (cpuRdPend) begin
			cpuRdHold <= ramRdData;
		end
	end

	//////////////////////////////
	// Byte capture
	//////////////////////////////

	// Attribute byte with a low byte held from the same slot
	assign fetchDone = rdVideo & rdByte & haveLow[rdLayer];
	assign tileCode  = {ramRdData[tilemapPkg::codeHighW-1:0], codeLow[rdLayer]};

	// Low byte arms the slot, attribute byte ends it
	// CPU cycle in the slot throws it away
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			haveLow <= '0;
		end else begin
			haveLow[rdLayer] <= rdVideo & ~rdByte;
		end
	end

	always_ff @(posedge CLK_6M) begin
		if (rdVideo && !rdByte) begin
			codeLow[rdLayer] <= ramRdData;
		end
	end

	//////////////////////////////
	// Graphics outputs
	//////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			gfxValidA <= 1'b0;
			gfxValidB <= 1'b0;
			hA2       <= 1'b0;
			hB2       <= 1'b0;
		end else begin
			gfxValidA <= fetchDone & ~rdLayer;
			gfxValidB <= fetchDone & rdLayer;
			// Half-tile flag for the pixel shifters
			hA2       <= fetchA.fineX[tilemapPkg::fineW-1];
			hB2       <= fetchB.fineX[tilemapPkg::fineW-1];
		end
	end

	always_ff @(posedge CLK_6M) begin
		if (fetchDone && !rdLayer) begin
			gfxAddrA <= {tileCode, rdFineY};
		end
		if (fetchDone && rdLayer) begin
			gfxAddrB <= {tileCode, rdFineY};
		end
	end

endmodule

// File: tilemapAddrGen.sv
`timescale 1ns/10ps

// Two-layer tilemap address generator
// Beam counter, per-layer stages and the shared RAM fetch
module tilemapAddrGen (
	input  logic                            CLK_6M,
	input  logic                            rstN,
	input  logic                            hSyncN,
	input  logic                            vSyncN,
	input  logic                            flip,
	// Scroll register port
	input  logic                            regWe,
	input  logic [2:0]                      regAddr,
	input  logic [7:0]                      regData,
	// CPU side of the tilemap RAM
	input  logic                            cpuSel,
	input  logic                            cpuWe,
	input  logic [tilemapPkg::ramAddrW-1:0] cpuAddr,
	input  logic [7:0]                      cpuWrData,
	output logic [7:0]                      cpuRdData,
	// Tilemap RAM
	output logic [tilemapPkg::ramAddrW-1:0] ramAddr,
	output logic [7:0]                      ramWrData,
	input  logic [7:0]                      ramRdData,
	output logic                            ramWe,
	output logic                            ramOe,
	// Graphics ROM side
	output logic [tilemapPkg::gfxAddrW-1:0] gfxAddrA,
	output logic [tilemapPkg::gfxAddrW-1:0] gfxAddrB,
	output logic                            gfxValidA,
	output logic                            gfxValidB,
	output logic                            hA2,
	output logic                            hB2
);

	videoTimingPkg::beamPos beam;
	tilemapPkg::layerScroll scrollA;
	tilemapPkg::layerScroll scrollB;
	tilemapPkg::layerFetch  fetchA;
	tilemapPkg::layerFetch  fetchB;

	beamCounter beamCounter_i (
		.CLK_6M (CLK_6M),
		.rstN   (rstN),
		.hSyncN (hSyncN),
		.vSyncN (vSyncN),
		.beam   (beam)
	);

	scrollRegs scrollRegs_i (
		.CLK_6M  (CLK_6M),
		.rstN    (rstN),
		.regWe   (regWe),
		.regAddr (regAddr),
		.regData (regData),
		.scrollA (scrollA),
		.scrollB (scrollB)
	);

	// Layer A
	layerAddrGen layerA_i (
		.CLK_6M (CLK_6M),
		.rstN   (rstN),
		.flip   (flip),
		.beam   (beam),
		.scroll (scrollA),
		.fetch  (fetchA)
	);

	// Layer B
	layerAddrGen layerB_i (
		.CLK_6M (CLK_6M),
		.rstN   (rstN),
		.flip   (flip),
		.beam   (beam),
		.scroll (scrollB),
		.fetch  (fetchB)
	);

	tileFetchMux tileFetchMux_i (
		.CLK_6M    (CLK_6M),
		.rstN      (rstN),
		.beam      (beam),
		.fetchA    (fetchA),
		.fetchB    (fetchB),
		.bankA     (scrollA.bank),
		.bankB     (scrollB.bank),
		.cpuSel    (cpuSel),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.ramAddr   (ramAddr),
		.ramWrData (ramWrData),
		.ramRdData (ramRdData),
		.ramWe     (ramWe),
		.ramOe     (ramOe),
		.gfxAddrA  (gfxAddrA),
		.gfxAddrB  (gfxAddrB),
		.gfxValidA (gfxValidA),
		.gfxValidB (gfxValidB),
		.hA2       (hA2),
		.hB2       (hB2)
	);

endmodule

// File: tilemapAddrGen_chk.sv
`timescale 1ns/10ps

// Port-level checks on the tilemap address generator
module tilemapAddrGen_chk (
	input logic        CLK_6M,
	input logic        rstN,
	input logic        cpuSel,
	input logic        cpuWe,
	input logic [12:0] cpuAddr,
	input logic [7:0]  cpuWrData,
	input logic [7:0]  cpuRdData,
	input logic [12:0] ramAddr,
	input logic [7:0]  ramWrData,
	input logic [7:0]  ramRdData,
	input logic        ramWe,
	input logic        ramOe,
	input logic        gfxValidA,
	input logic        gfxValidB
);

	// Failed assertions so far
	int errCount = 0;

	//////////////////////////////
	// RAM port ownership
	//////////////////////////////

	// Write strobe only with the CPU's address and data on the bus
	assert property (@(posedge CLK_6M) ramWe |->
		(cpuSel && cpuWe && ramAddr == cpuAddr && ramWrData == cpuWrData))
		else begin
			errCount++;
			$error("ramWe without matching CPU write");
		end

	// CPU write always reaches the RAM
	assert property (@(posedge CLK_6M) (cpuSel && cpuWe) |-> ramWe)
		else begin
			errCount++;
			$error("CPU write not passed to RAM");
		end

	// CPU read drives the RAM output and a CPU write keeps it off
	assert property (@(posedge CLK_6M) cpuSel |-> (ramOe == !cpuWe))
		else begin
			errCount++;
			$error("ramOe wrong during a CPU cycle");
		end

	// Video owns the RAM for reads only
	assert property (@(posedge CLK_6M) !cpuSel |-> (!ramWe && ramOe))
		else begin
			errCount++;
			$error("RAM strobes wrong while video owns it");
		end

	// Read data one cycle after the read cycle
	assert property (@(posedge CLK_6M) disable iff (!rstN)
		(cpuSel && !cpuWe) |=> (cpuRdData == ramRdData))
		else begin
			errCount++;
			$error("cpuRdData not the RAM byte");
		end

	//////////////////////////////
	// Valid pulses
	//////////////////////////////

	// Low right after a reset cycle
	assert property (@(posedge CLK_6M) !rstN |=> (!gfxValidA && !gfxValidB))
		else begin
			errCount++;
			$error("Valid high after reset");
		end

	// One layer at a time and one cycle wide
	assert property (@(posedge CLK_6M) disable iff (!rstN) !(gfxValidA && gfxValidB))
		else begin
			errCount++;
			$error("Both layers valid together");
		end

	assert property (@(posedge CLK_6M) disable iff (!rstN) gfxValidA |=> !gfxValidA)
		else begin
			errCount++;
			$error("gfxValidA longer than one cycle");
		end

endmodule

bind tilemapAddrGen tilemapAddrGen_chk chk_i (.*);

// File: tilemapAddrGen_tb.sv
`timescale 1ns/10ps

// Synchronous 8K tilemap RAM preloaded with an address pattern
module tilemapRam (
	input  logic        CLK_6M,
	input  logic        we,
	input  logic [12:0] addr,
	input  logic [7:0]  wrData,
	output logic [7:0]  rdData
);
	logic [7:0] mem [8192];

	// Low address byte XOR upper address bits
	initial begin
		for (int i = 0; i < 8192; i++) begin
			mem[i] = i[7:0] ^ {3'b000, i[12:8]};
		end
	end

	always @(posedge CLK_6M) begin
		if (we) begin
			mem[addr] <= wrData;
		end
		rdData <= mem[addr];
	end
endmodule

module tilemapAddrGen_tb;
	localparam int clkPeriod = 10;
	localparam int lineLen = 64;
	localparam int frameLines = 12;
	localparam int roundCycles = 300;
	localparam int rounds = 6;
	localparam int cpuOps = 16;
	localparam int testCycles = 5 + 200 + rounds * (roundCycles + 40) + cpuOps * 30 + 20;

	logic CLK_6M = 1'b0;
	logic rstN, hSyncN, vSyncN, flip, regWe, cpuSel, cpuWe;
	logic [2:0] regAddr;
	logic [7:0] regData, cpuWrData, cpuRdData, ramWrData, ramRdData;
	logic [12:0] cpuAddr, ramAddr;
	logic ramWe, ramOe, gfxValidA, gfxValidB, hA2, hB2;
	logic [13:0] gfxAddrA, gfxAddrB;

	// Reference state
	logic [8:0] scrX [2];
	logic [8:0] scrY [2];
	logic flipVal;
	time changeTime;
	logic [8:0] hRef, vRef;
	logic hPrev, vPrev;
	logic [8:0] hHist [5];
	logic [8:0] vHist [5];
	logic cpuHist [3];
	int sinceReset = 0;
	int checkErrors = 0;
	int readErrors = 0;
	int lineCnt = 0;
	int frameLine = 0;

	always #(clkPeriod / 2) CLK_6M = ~CLK_6M;

	tilemapAddrGen tilemapAddrGen_i (.*);

	tilemapRam ram_i (.CLK_6M(CLK_6M), .we(ramWe), .addr(ramAddr), .wrData(ramWrData),
		.rdData(ramRdData));

	////////////////////////////////
	// Sync strobes with a short line and frame
	always @(posedge CLK_6M) begin
		lineCnt <= (lineCnt == lineLen - 1) ? 0 : lineCnt + 1;
		if (lineCnt == lineLen - 1) begin
			frameLine <= (frameLine == frameLines - 1) ? 0 : frameLine + 1;
		end
		hSyncN <= !(lineCnt < 4);
		vSyncN <= !(frameLine == 0 && lineCnt < 4);
	end

	// Preload pattern of the tilemap RAM
	function automatic logic [7:0] patByte(input logic [12:0] a);
		return a[7:0] ^ {3'b000, a[12:8]};
	endfunction

	// Tilemap RAM address of one beam position
	function automatic logic [12:0] mapAddr(input logic lay, input logic [8:0] h,
			input logic [8:0] v, input logic [8:0] sx, input logic [8:0] sy, input logic fl);
		logic [8:0] x;
		logic [8:0] y;
		x = (fl ? ~h : h) + sx;
		y = (fl ? ~v : v) + sy;
		return {lay, y[7:3], x[8:3], h[0]};
	endfunction

	function automatic logic [2:0] fineYOf(input logic [8:0] v, input logic [8:0] sy,
			input logic fl);
		logic [8:0] y;
		y = (fl ? ~v : v) + sy;
		return y[2:0];
	endfunction

	// Bit 2 is the half-tile flag
	function automatic logic [2:0] fineXOf(input logic [8:0] h, input logic [8:0] sx,
			input logic fl);
		logic [8:0] x;
		x = (fl ? ~h : h) + sx;
		return x[2:0];
	endfunction

	////////////////////////////////
	// Beam model and history built from the strobes seen at each edge
	always @(posedge CLK_6M) begin
		if (!rstN) begin
			hRef = '0;
			vRef = '0;
			hPrev = 1'b1;
			vPrev = 1'b1;
			sinceReset = 0;
		end else begin
			if (vPrev && !vSyncN) vRef = '0;
			else if (hPrev && !hSyncN) vRef = vRef + 9'd1;
			hRef = (hPrev && !hSyncN) ? 9'd0 : hRef + 9'd1;
			hPrev = hSyncN;
			vPrev = vSyncN;
			sinceReset++;
		end
		for (int i = 4; i > 0; i--) begin
			hHist[i] = hHist[i-1];
			vHist[i] = vHist[i-1];
		end
		hHist[0] = hRef;
		vHist[0] = vRef;
		cpuHist[2] = cpuHist[1];
		cpuHist[1] = cpuHist[0];
		cpuHist[0] = cpuSel;
	end

	// Pulse and address checks between edges
	always @(negedge CLK_6M) begin
		logic lay;
		logic expPulse;
		logic [12:0] a0;
		logic [12:0] a1;
		logic [7:0] attr;
		logic [13:0] expAddr;
		logic [2:0] fxA;
		logic [2:0] fxB;
		if (sinceReset >= 6) begin
			// Byte 0 then byte 1 of one slot with no CPU cycle in between
			expPulse = hHist[3][0] && (hHist[4] == hHist[3] - 9'd1)
				&& !cpuHist[1] && !cpuHist[2];
			lay = hHist[3][1];
			a0 = mapAddr(lay, hHist[4], vHist[4], scrX[lay], scrY[lay], flipVal);
			a1 = mapAddr(lay, hHist[3], vHist[3], scrX[lay], scrY[lay], flipVal);
			attr = patByte(a1);
			expAddr = {attr[2:0], patByte(a0), fineYOf(vHist[3], scrY[lay], flipVal)};
			// Half-tile flags follow the beam two edges back
			fxA = fineXOf(hHist[2], scrX[0], flipVal);
			fxB = fineXOf(hHist[2], scrX[1], flipVal);
			assert (gfxValidA === (expPulse && !lay)) else begin
				checkErrors++;
				$display("FAILED gfxValidA: got %h expected %h", gfxValidA, expPulse && !lay);
			end
			assert (gfxValidB === (expPulse && lay)) else begin
				checkErrors++;
				$display("FAILED gfxValidB: got %h expected %h", gfxValidB, expPulse && lay);
			end
			// Addresses are skipped while settings or RAM settle
			if (expPulse && ($time - changeTime > 8 * clkPeriod)) begin
				if (!lay) assert (gfxAddrA === expAddr) else begin
					checkErrors++;
					$display("FAILED gfxAddrA: got %h expected %h", gfxAddrA, expAddr);
				end
				if (lay) assert (gfxAddrB === expAddr) else begin
					checkErrors++;
					$display("FAILED gfxAddrB: got %h expected %h", gfxAddrB, expAddr);
				end
			end
			if ($time - changeTime > 8 * clkPeriod) begin
				assert (hA2 === fxA[2]) else begin
					checkErrors++;
					$display("FAILED hA2: got %h expected %h", hA2, fxA[2]);
				end
				assert (hB2 === fxB[2]) else begin
					checkErrors++;
					$display("FAILED hB2: got %h expected %h", hB2, fxB[2]);
				end
			end
		end
	end

	////////////////////////////////
	// Stimulus tasks
	task automatic writeReg(input logic [2:0] a, input logic [7:0] d);
		@(posedge CLK_6M);
		regWe <= 1'b1;
		regAddr <= a;
		regData <= d;
		@(posedge CLK_6M);
		regWe <= 1'b0;
	endtask

	task automatic setScroll(input logic lay, input logic [8:0] sx, input logic [7:0] sy);
		scrX[lay] = sx;
		scrY[lay] = {1'b0, sy};
		changeTime = $time;
		writeReg({lay, 2'd0}, {7'd0, sx[8]});
		writeReg({lay, 2'd1}, sx[7:0]);
		writeReg({lay, 2'd2}, sy);
		writeReg({lay, 2'd3}, 8'($urandom));
		changeTime = $time;
	endtask

	task automatic cpuAccess(input logic we, input logic [12:0] a, input logic [7:0] d);
		@(posedge CLK_6M);
		cpuSel <= 1'b1;
		cpuWe <= we;
		cpuAddr <= a;
		cpuWrData <= d;
		@(posedge CLK_6M);
		cpuSel <= 1'b0;
		cpuWe <= 1'b0;
		if (we) changeTime = $time;
	endtask

	// Single read with the byte checked one cycle later
	task automatic cpuReadCheck(input logic [12:0] a, input logic [7:0] exp);
		cpuAccess(1'b0, a, 8'h00);
		@(negedge CLK_6M);
		assert (cpuRdData === exp) else begin
			readErrors++;
			$display("FAILED cpuRdData: got %h expected %h", cpuRdData, exp);
		end
	endtask

	////////////////////////////////
	// Main sequence
	initial begin
		logic [12:0] a;
		logic [7:0] d;
		int total;
		void'($urandom(43));
		{rstN, flip, regWe, cpuSel, cpuWe, flipVal} = '0;
		{hSyncN, vSyncN} = 2'b11;
		{regAddr, regData, cpuAddr, cpuWrData} = '0;
		scrX = '{default: '0};
		scrY = '{default: '0};
		changeTime = 0;
		repeat (5) @(posedge CLK_6M);
		rstN <= 1'b1;
		repeat (200) @(posedge CLK_6M);
		// Random scroll with flip on in the last two rounds
		for (int r = 0; r < rounds; r++) begin
			@(posedge CLK_6M);
			flipVal = (r >= rounds - 2);
			flip <= flipVal;
			changeTime = $time;
			setScroll(1'b0, 9'($urandom), 8'($urandom));
			setScroll(1'b1, 9'($urandom), 8'($urandom));
			repeat (roundCycles) @(posedge CLK_6M);
		end
		// CPU cycles cutting into fetch slots
		for (int n = 0; n < cpuOps; n++) begin
			a = 13'($urandom);
			d = 8'($urandom);
			cpuAccess(1'b1, a, d);
			cpuReadCheck(a, d);
			cpuAccess(1'b1, a, patByte(a));
			a = 13'($urandom);
			cpuReadCheck(a, patByte(a));
			repeat (3 + $urandom % 8) @(posedge CLK_6M);
		end
		repeat (20) @(posedge CLK_6M);
		total = checkErrors + readErrors + tilemapAddrGen_i.chk_i.errCount;
		$display("Errors: %0d check, %0d read, %0d assertion", checkErrors, readErrors,
			tilemapAddrGen_i.chk_i.errCount);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog over the whole test length plus margin
	initial begin
		#(testCycles * clkPeriod + 2000);
		$display("Timeout, test did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end
endmodule

// File: src.f
videoTimingPkg.sv
tilemapPkg.sv
beamCounter.sv
scrollRegs.sv
layerAddrGen.sv
tileFetchMux.sv
tilemapAddrGen.sv
tilemapAddrGen_chk.sv
tilemapAddrGen_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tilemapAddrGen_tb
FILELIST  := src.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD)
